/* common/st_glue_settings.svh */
// Clock rates, FIFO depths, control word bit positions and redirection code
`ifndef ST_GLUE_SETTINGS_SVH
`define ST_GLUE_SETTINGS_SVH

// System clock in Hz, the 32 MHz core clock
`define ST_SYSTEM_CLOCK 32_084_988

// MFP timer clock in Hz
`define ST_MFP_CLOCK 2_457_600

// Width of the fractional MFP accumulator
`define ST_MFP_ACC_W 32

// FIFO depths in bytes
`define ST_MIDI_FIFO_DEPTH 16
`define ST_PAR_FIFO_DEPTH 4

// Control word, lowest bit of each field
`define ST_CTRL_SCAN_LO 20 // Scanline mode, 2 bits
`define ST_CTRL_REDIR_LO 26 // USB redirection, 2 bits
`define ST_CTRL_BLEND 29 // Scaler blend enable

// USB redirection target: 0 none, 1 rs232, 2 printer, 3 midi
`define ST_REDIR_PRINTER 2

`endif

/* common/st_glue_pkg.sv */
// Shared typedefs and packed structs for the ST glue logic
`default_nettype none
`include "st_glue_settings.svh"

package st_glue_pkg;

	typedef logic [7:0] byte_t; // Data byte
	typedef logic [3:0] color_t; // One colour component
	typedef logic [15:0] joy_t; // Bit 0 right, 1 left, 2 down, 3 up, 4 fire
	typedef logic [1:0] redir_t; // 0 none, 1 rs232, 2 printer, 3 midi
	typedef logic [1:0] scanline_t;

	// System control word as sent by the I/O controller
	typedef struct packed {
		logic [31-`ST_CTRL_BLEND-1:0] rsvd_hi;
		logic blend;
		logic [`ST_CTRL_BLEND-`ST_CTRL_REDIR_LO-3:0] rsvd_mid;
		redir_t redirection;
		logic [`ST_CTRL_REDIR_LO-`ST_CTRL_SCAN_LO-3:0] rsvd_lo;
		scanline_t scanlines;
		logic [`ST_CTRL_SCAN_LO-1:0] rsvd_base; // Reset, write protect etc, unused here
	} sys_ctrl_t;

	typedef struct packed {
		color_t r, g, b;
		logic hs, vs, hb, vb; // Active high blanking
	} video_t;

	// Raw ST shifter side, active low syncs and blanks
	typedef struct packed {
		logic mono; // Monochrome monitor mode
		color_t r, g, b;
		logic hsync_n, vsync_n, hblank_n, vblank_n;
	} st_video_t;

	typedef struct packed {
		logic blend;
		logic scandoubler_off;
		logic no_csync;
		scanline_t scanlines;
	} scaler_ctrl_t;

	typedef struct packed {
		byte_t data; // Oldest byte, valid while available
		logic available;
		logic spare;
	} fifo_rd_t;

endpackage

`default_nettype wire

/* logic/mfp_clock_gen.sv */
// Fractional accumulator producing the 2.4576 MHz MFP clock enable
`default_nettype none
`include "st_glue_settings.svh"

module mfp_clock_gen
	import st_glue_pkg::*;
(
	input wire logic clk_32,
	input wire logic reset,
	output logic mfp_en // One cycle pulse, average MFP rate
);

	localparam int W = `ST_MFP_ACC_W;
	localparam logic [W-1:0] SYS_RATE = W'(`ST_SYSTEM_CLOCK);
	localparam logic [W-1:0] MFP_RATE = W'(`ST_MFP_CLOCK);

	logic [W-1:0] acc; // Phase in units of 1/SYSTEM seconds

	always_ff @(posedge clk_32) begin
		if (reset) begin
			acc <= '0;
			mfp_en <= 1'b0;
		end else begin
			mfp_en <= 1'b0; // Default no pulse
			if (acc < SYS_RATE) begin
				acc <= acc + MFP_RATE;
			end else begin
				// Wrap and keep the remainder, this bounds the jitter
				acc <= acc - SYS_RATE + MFP_RATE;
				mfp_en <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/io_fifo.sv */
// First-word-fall-through byte FIFO with strobe write and strobe read
`default_nettype none

module io_fifo
	import st_glue_pkg::*;
#(
	parameter int DEPTH = 4
) (
	input wire logic clk_32,
	input wire logic reset,
	input wire logic wr, // Single cycle write strobe
	input wire byte_t wr_data,
	input wire logic rd, // Single cycle read strobe, pops head
	output fifo_rd_t rd_side,
	output logic full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

	byte_t mem [DEPTH]; // Payload storage
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count; // Bytes held
	logic do_wr;
	logic do_rd;

	// Drop writes when full, ignore reads when empty
	assign full = (count == CW'(DEPTH));
	assign do_wr = wr & ~full;
	assign do_rd = rd & (count != '0);

	// Head byte shown without read latency
	assign rd_side.data = mem[rd_ptr];
	assign rd_side.available = (count != '0);
	assign rd_side.spare = 1'b0;

	always_ff @(posedge clk_32) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk_32) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1; // Wrap for any depth
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or none, occupancy unchanged
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/parallel_port.sv */
// Printer output FIFO, printer busy selection and gauntlet joystick mapping
`default_nettype none
`include "st_glue_settings.svh"

module parallel_port
	import st_glue_pkg::*;
(
	input wire logic clk_32,
	input wire logic reset,
	input wire sys_ctrl_t sys_ctrl,
	input wire logic par_wr, // PSG port write from the ST
	input wire byte_t par_byte,
	input wire logic par_rd, // I/O controller pops a byte
	input wire joy_t joy2,
	input wire joy_t joy3,
	output fifo_rd_t par_rd_side,
	output logic printer_busy,
	output byte_t par_in, // Parallel input as seen by the ST
	output logic par_in_strobe
);

	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT = 1;
	localparam int JOY_DOWN = 2;
	localparam int JOY_UP = 3;
	localparam int JOY_FIRE = 4;

	logic par_full;

	io_fifo #(
		.DEPTH(`ST_PAR_FIFO_DEPTH)
	) u_par_fifo (
		.clk_32 (clk_32),
		.reset (reset),
		.wr (par_wr),
		.wr_data (par_byte),
		.rd (par_rd),
		.rd_side (par_rd_side),
		.full (par_full)
	);

	// Busy from the FIFO only while the USB port acts as printer
	// Otherwise the line carries fire of the first gauntlet stick
	assign printer_busy = (sys_ctrl.redirection == redir_t'(`ST_REDIR_PRINTER)) ?
		par_full : joy2[JOY_FIRE];

	// Gauntlet adapter, pressed pulls the line low
	assign par_in = {~joy2[JOY_RIGHT], ~joy2[JOY_LEFT], ~joy2[JOY_DOWN], ~joy2[JOY_UP],
		~joy3[JOY_RIGHT], ~joy3[JOY_LEFT], ~joy3[JOY_DOWN], ~joy3[JOY_UP]};
	assign par_in_strobe = ~joy3[JOY_FIRE]; // Second stick fire on the strobe line

endmodule

`default_nettype wire

/* logic/video_select.sv */
// Registered Viking/ST video source selection, colour blanking and scaler flags
`default_nettype none

module video_select
	import st_glue_pkg::*;
(
	input wire logic clk_32,
	input wire logic reset,
	input wire sys_ctrl_t sys_ctrl,
	input wire st_video_t st_video,
	input wire video_t viking_video,
	input wire logic viking_active, // Viking card drives the screen
	input wire logic scandoubler_req, // Controller asks for no scandoubler
	input wire logic no_csync_req,
	output video_t video_out,
	output scaler_ctrl_t scaler
);

	logic mono;
	logic st_blank_n; // High while ST picture is visible
	video_t st_path;
	video_t video_next;
	scaler_ctrl_t scaler_next;

	assign mono = st_video.mono;
	assign st_blank_n = st_video.hblank_n & st_video.vblank_n;

	// Colour only inside the visible area, mono keeps it always
	assign st_path.r = (st_blank_n | mono) ? st_video.r : '0;
	assign st_path.g = (st_blank_n | mono) ? st_video.g : '0;
	assign st_path.b = (st_blank_n | mono) ? st_video.b : '0;
	assign st_path.hs = st_video.hsync_n; // Syncs pass unchanged
	assign st_path.vs = st_video.vsync_n;
	assign st_path.hb = ~st_video.hblank_n;
	assign st_path.vb = ~st_video.vblank_n;

	assign video_next = viking_active ? viking_video : st_path;

	// Mono and Viking modes bypass the scandoubler entirely
	assign scaler_next.blend = sys_ctrl.blend & ~mono & ~viking_active;
	assign scaler_next.scandoubler_off = scandoubler_req | mono | viking_active;
	assign scaler_next.no_csync = no_csync_req | mono | viking_active;
	assign scaler_next.scanlines = sys_ctrl.scanlines;

	always_ff @(posedge clk_32) begin
		if (reset) begin
			video_out <= '0;
			scaler <= '0;
		end else begin
			video_out <= video_next; // One cycle latency
			scaler <= scaler_next;
		end
	end

endmodule

`default_nettype wire

/* logic/st_glue_top.sv */
// Top level of the ST I/O glue, MFP clock, MIDI FIFO, parallel port and video select
`default_nettype none
`include "st_glue_settings.svh"

module st_glue_top
	import st_glue_pkg::*;
(
	input wire logic clk_32,
	input wire logic reset,
	input wire sys_ctrl_t sys_ctrl,
	input wire logic midi_wr, // ACIA data write
	input wire byte_t midi_byte,
	input wire logic par_wr,
	input wire byte_t par_byte,
	input wire logic midi_rd, // I/O controller reads
	input wire logic par_rd,
	input wire joy_t joy2,
	input wire joy_t joy3,
	input wire st_video_t st_video,
	input wire video_t viking_video,
	input wire logic viking_active,
	input wire logic scandoubler_req,
	input wire logic no_csync_req,
	output logic mfp_en,
	output fifo_rd_t midi_rd_side,
	output fifo_rd_t par_rd_side,
	output logic printer_busy,
	output byte_t par_in,
	output logic par_in_strobe,
	output video_t video_out,
	output scaler_ctrl_t scaler
);

	mfp_clock_gen u_mfp_clock_gen (
		.clk_32 (clk_32),
		.reset (reset),
		.mfp_en (mfp_en)
	);

	// MIDI full stays internal, overflow just drops bytes
	io_fifo #(
		.DEPTH(`ST_MIDI_FIFO_DEPTH)
	) u_midi_fifo (
		.clk_32 (clk_32),
		.reset (reset),
		.wr (midi_wr),
		.wr_data (midi_byte),
		.rd (midi_rd),
		.rd_side (midi_rd_side),
		.full ()
	);

	parallel_port u_parallel_port (
		.clk_32 (clk_32),
		.reset (reset),
		.sys_ctrl (sys_ctrl),
		.par_wr (par_wr),
		.par_byte (par_byte),
		.par_rd (par_rd),
		.joy2 (joy2),
		.joy3 (joy3),
		.par_rd_side (par_rd_side),
		.printer_busy (printer_busy),
		.par_in (par_in),
		.par_in_strobe (par_in_strobe)
	);

	video_select u_video_select (
		.clk_32 (clk_32),
		.reset (reset),
		.sys_ctrl (sys_ctrl),
		.st_video (st_video),
		.viking_video (viking_video),
		.viking_active (viking_active),
		.scandoubler_req (scandoubler_req),
		.no_csync_req (no_csync_req),
		.video_out (video_out),
		.scaler (scaler)
	);

endmodule

`default_nettype wire

/* tests/st_glue_sva.sv */
// Bound assertions on the FIFO flags, the write strobe width and the reset state
`default_nettype none

module st_glue_sva (
	input wire logic clk_32,
	input wire logic reset,
	input wire logic wr,
	input wire logic rd,
	input wire logic empty, // Occupancy count at zero
	input wire logic available,
	input wire logic full
);

	// A write into an empty buffer always lands
	a_empty_flags: assert property (@(posedge clk_32) disable iff (reset)
		(empty && wr) |=> available)
		else $error("FIFO write into an empty buffer left available low");

	// Writes while full are dropped, so full holds until a read
	a_full_drop: assert property (@(posedge clk_32) disable iff (reset)
		(full && !rd) |=> full)
		else $error("FIFO full flag fell without a read");

	a_wr_single: assert property (@(posedge clk_32) disable iff (reset) wr |=> !wr)
		else $error("FIFO write strobe held for two cycles");

	// Sync reset clears the count at the edge
	a_reset_empty: assert property (@(posedge clk_32) reset |=> !available)
		else $error("FIFO available high in the cycle after reset");

endmodule

bind io_fifo st_glue_sva u_sva (
	.clk_32 (clk_32),
	.reset (reset),
	.wr (wr),
	.rd (rd),
	.empty (count == '0),
	.available (rd_side.available),
	.full (full)
);

`default_nettype wire

/* tests/st_glue_tb.sv */
// Testbench for the ST glue top with case file stimulus, compare tasks and watchdog
`default_nettype none
`include "st_glue_settings.svh"

module st_glue_tb
	import st_glue_pkg::*;
;

	localparam int MIDI_DEPTH = `ST_MIDI_FIFO_DEPTH;
	localparam int PAR_DEPTH = `ST_PAR_FIFO_DEPTH;

	logic clk_32, reset, midi_wr, par_wr, midi_rd, par_rd;
	logic viking_active, scandoubler_req, no_csync_req;
	sys_ctrl_t sys_ctrl;
	byte_t midi_byte, par_byte, par_in;
	joy_t joy2, joy3;
	st_video_t st_video;
	video_t viking_video, video_out;
	logic mfp_en, printer_busy, par_in_strobe;
	fifo_rd_t midi_rd_side, par_rd_side;
	scaler_ctrl_t scaler;

	logic [7:0] op_q[$]; // Parsed opcodes
	logic [5:0][31:0] arg_q[$];
	byte_t midi_q[$], par_q[$]; // Reference FIFO contents
	logic [31:0] lfsr = 32'h2b5b;
	int cycles = 0;
	int limit = 100_000; // Replaced once the case file is counted

	st_glue_top u_dut (.*);

	initial begin
		clk_32 = 1'b0;
		forever #10 clk_32 = ~clk_32;
	end

	task end_with_failure();
		$display("Checks failed");
		$fatal(1);
	endtask

	always @(posedge clk_32) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			end_with_failure();
		end
	end

	task next_cycle(); // Inputs change and outputs are sampled here
		@(negedge clk_32);
	endtask

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task random_byte(output byte_t b);
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr[0]}; // One step per bit
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("Fail %s got %h expected %h", name, got, exp);
			end_with_failure();
		end
	endtask

	task check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s got %h expected %h", name, got, exp);
			end_with_failure();
		end
	endtask

	task check_video(input string name, input video_t got, input video_t exp);
		if (got !== exp) begin
			$display("Fail %s got %h expected %h", name, got, exp);
			end_with_failure();
		end
	endtask

	task check_scaler(input string name, input scaler_ctrl_t got, input scaler_ctrl_t exp);
		if (got !== exp) begin
			$display("Fail %s got %h expected %h", name, got, exp);
			end_with_failure();
		end
	endtask

	task check_count(input string name, input int got, input int exp);
		if (got > exp + 1 || got + 1 < exp) begin // Jitter of one pulse allowed
			$display("Fail %s got %h expected %h", name, got, exp);
			end_with_failure();
		end
	endtask

	function automatic int arg_count(input logic [7:0] op);
		case (op)
			"M", "W", "R": arg_count = 2;
			"J": arg_count = 6;
			"V": arg_count = 5;
			default: arg_count = 0; // Unknown opcode
		endcase
	endfunction

	task read_cases();
		int fd, ch, window;
		logic [7:0] op;
		logic [31:0] val;
		logic [5:0][31:0] args;
		window = 0;
		fd = $fopen("tests/st_glue_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file tests/st_glue_cases.txt");
			end_with_failure();
		end
		while ($fscanf(fd, " %c", op) == 1) begin
			if (op == "#") begin
				ch = 0;
				while (ch != 10 && ch != -1) ch = $fgetc(fd); // Skip comment line
			end else begin
				if (arg_count(op) == 0) begin
					$display("Unknown opcode in the case file");
					end_with_failure();
				end
				args = '0;
				for (int i = 0; i < arg_count(op); i++) begin
					if ($fscanf(fd, "%h", val) != 1) begin
						$display("Case file line has too few operands");
						end_with_failure();
					end
					args[i] = val;
				end
				if (op == "M") window += int'(args[0]);
				op_q.push_back(op);
				arg_q.push_back(args);
			end
		end
		$fclose(fd);
		limit = 2 * (op_q.size() * 20 + window);
	endtask

	task run_case(input logic [7:0] op, input logic [5:0][31:0] args);
		int pulses;
		logic prev;
		byte_t b;
		pulses = 0;
		prev = 1'b0;
		case (op)
			"M": begin
				for (int n = 0; n < int'(args[0]); n++) begin
					next_cycle();
					if (mfp_en && prev) begin
						$display("The mfp_en pulse stayed high for two cycles");
						end_with_failure();
					end
					if (mfp_en) pulses++;
					prev = mfp_en;
				end
				check_count("mfp_en pulses", pulses, int'(args[1]));
			end
			"W": begin
				for (int n = 0; n < int'(args[1]); n++) begin
					random_byte(b);
					if (args[0] == 0) begin
						midi_byte = b;
						midi_wr = 1'b1;
						if (midi_q.size() < MIDI_DEPTH) midi_q.push_back(b);
					end else begin
						par_byte = b;
						par_wr = 1'b1;
						if (par_q.size() < PAR_DEPTH) par_q.push_back(b); // Full drops it
					end
					next_cycle();
					midi_wr = 1'b0;
					par_wr = 1'b0;
					next_cycle(); // Gap keeps strobes single
				end
			end
			"R": begin
				for (int n = 0; n < int'(args[1]); n++) begin
					if (args[0] == 0) begin
						check_flag("midi available", midi_rd_side.available, midi_q.size() != 0);
						if (midi_q.size() != 0) begin
							check_byte("midi data", midi_rd_side.data, midi_q.pop_front());
						end
						midi_rd = 1'b1;
					end else begin
						check_flag("par available", par_rd_side.available, par_q.size() != 0);
						if (par_q.size() != 0) begin
							check_byte("par data", par_rd_side.data, par_q.pop_front());
						end
						par_rd = 1'b1;
					end
					next_cycle();
					midi_rd = 1'b0;
					par_rd = 1'b0;
					next_cycle();
				end
			end
			"J": begin
				sys_ctrl.redirection = redir_t'(args[0][1:0]);
				joy2 = args[1][15:0];
				joy3 = args[2][15:0];
				next_cycle();
				check_byte("par_in", par_in, args[3][7:0]);
				check_flag("par_in_strobe", par_in_strobe, args[4][0]);
				check_flag("printer_busy", printer_busy, args[5][0]);
			end
			default: begin // V, one registered stage
				st_video = args[0][16:0];
				viking_video = args[1][15:0];
				viking_active = args[2][0];
				scandoubler_req = args[2][1];
				no_csync_req = args[2][2];
				sys_ctrl.blend = args[2][3];
				sys_ctrl.scanlines = args[2][5:4];
				next_cycle();
				check_video("video_out", video_out, args[3][15:0]);
				check_scaler("scaler", scaler, args[4][4:0]);
			end
		endcase
	endtask

	initial begin
		reset = 1'b1;
		sys_ctrl = '0;
		{midi_wr, par_wr, midi_rd, par_rd} = '0;
		midi_byte = '0;
		par_byte = '0;
		joy2 = '0;
		joy3 = '0;
		st_video = '0;
		viking_video = '0;
		{viking_active, scandoubler_req, no_csync_req} = '0;
		read_cases();
		repeat (16) next_cycle();
		reset = 1'b0;
		check_flag("mfp_en", mfp_en, 1'b0); // Reset state
		check_flag("midi available", midi_rd_side.available, 1'b0);
		check_flag("par available", par_rd_side.available, 1'b0);
		check_video("video_out", video_out, '0);
		check_scaler("scaler", scaler, '0);
		for (int k = 0; k < op_q.size(); k++) run_case(op_q[k], arg_q[k]);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/st_glue_pkg.sv
logic/mfp_clock_gen.sv
logic/io_fifo.sv
logic/parallel_port.sv
logic/video_select.sv
logic/st_glue_top.sv
tests/st_glue_sva.sv
tests/st_glue_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module st_glue_tb -f verilog.f \
	&& ./obj_dir/Vst_glue_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log 2>/dev/null && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* tests/st_glue_cases.txt */
# Ops: M window pulses | W port n | R port n (port 0 midi, 1 printer), all hex
# J redir joy2 joy3 par_in strobe busy | V st_video viking flags video_out scaler
# V flags: bit0 viking, bit1 scandoubler_req, bit2 no_csync_req, bit3 blend, 5:4 scanlines
M 2710 2fd
W 0 a
R 0 a
R 0 1
J 2 0000 0000 ff 1 0
W 1 3
J 2 0000 0000 ff 1 0
W 1 1
J 2 0000 0000 ff 1 1
W 1 2
J 2 0000 0000 ff 1 1
R 1 1
J 2 0000 0000 ff 1 0
R 1 3
R 1 1
W 1 4
J 2 0000 0000 ff 1 1
J 0 0010 0000 ff 1 1
J 0 0000 0000 ff 1 0
J 0 0001 0008 7e 1 0
J 0 001a 0015 a5 0 1
J 0 ffe4 0003 d3 1 0
R 1 4
V 0abcf 5a3c 29 5a3c 0e
V 0abcb 0000 18 abc8 11
V 0abc5 0000 02 0006 08
V 1f0fc 0000 0c f0ff 0c
V 01232 0000 30 0001 03
